/* verification/spi_patterns.txt */
# op and hex operands: W addr data, R addr expect, T tx byte, C rx credits, E rx byte
# I waits for the engine to go idle, P gives the expected spi_ss_n level
# reset state, only the two empty flags are set
R 1 0006
R 0 0000
# single byte, half period 3, held in the rx queue until a credit comes
W 0 0301
R 0 0301
T a5
I
R 1 000a
C 1
E ad
I
W 0 0300
I
P 1
# burst of four in a fresh select window
W 0 0301
T 3c
T 81
T 7e
T 00
C 4
E e1
E bf
E 40
E ff
I
# no rx credits, rx queue fills and the engine stalls
T 11
T 22
T 44
T 88
T f0
T 0f
I
R 1 0008
C 6
E f7
E 6e
E dd
E bb
E 87
E f8
I
R 1 000e
# half period 7, select cleared while the byte runs
W 0 0701
T 5a
W 0 0700
C 1
E 52
I
P 1
R 0 0700
R 1 0006

/* files.f */
hw/spi_regmap_pkg.sv
hw/spi_link_pkg.sv
hw/byte_fifo.sv
hw/spi_byte_engine.sv
hw/spi_ctrl_regs.sv
hw/rx_credit_sender.sv
hw/spi_flash_port.sv
verification/spi_flash_model.sv
verification/spi_flash_port_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module spi_flash_port_tb -o spi_flash_port_sim
./obj_dir/spi_flash_port_sim | tee sim.log
if grep -qF '*** PASSED ***' sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi

/* verification/spi_flash_port_tb.sv */
`timescale 1ns/1ps

module spi_flash_port_tb
  import spi_regmap_pkg::*, spi_link_pkg::*;
();

  localparam int TX_DEPTH = DEF_TX_DEPTH;
  localparam int RX_DEPTH = DEF_RX_DEPTH;
  // cycles allowed for any single wait
  localparam int TIMEOUT  = 20000;

  logic                  clk;
  logic                  reset_n;
  logic                  reg_wr;
  logic                  reg_rd;
  reg_addr_e             reg_addr;
  logic [REG_DATA_W-1:0] reg_wdata;
  logic [REG_DATA_W-1:0] reg_rdata;
  logic                  tx_valid;
  spi_byte_t             tx_data;
  logic                  tx_credit;
  logic                  rx_valid;
  spi_byte_t             rx_data;
  logic                  rx_credit;
  logic                  spi_ss_n;
  logic                  spi_sck;
  logic                  spi_mosi;
  logic                  spi_miso;

  integer    mismatches;
  integer    other_errors;
  // host side credit bookkeeping
  integer    host_credits;
  integer    tx_sent;
  integer    tx_pulses;
  integer    rx_owed;
  // sck timing watch
  integer    exp_half;
  integer    high_cnt;
  // sck rises still due from bytes the engine has started
  integer    rises_owed;
  logic      prev_sck;
  logic      prev_ss_n;
  logic      monitor_on;
  logic      aborted;
  // rx bytes delivered to the host in arrival order
  spi_byte_t rx_seen [$];

  spi_flash_port #(.TX_DEPTH(TX_DEPTH), .RX_DEPTH(RX_DEPTH)) spi_flash_port_i (
    .clk(clk), .reset_n(reset_n), .reg_wr(reg_wr), .reg_rd(reg_rd),
    .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
    .tx_valid(tx_valid), .tx_data(tx_data), .tx_credit(tx_credit),
    .rx_valid(rx_valid), .rx_data(rx_data), .rx_credit(rx_credit),
    .spi_ss_n(spi_ss_n), .spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
  );

  spi_flash_model flash_model (
    .spi_ss_n(spi_ss_n), .spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //----------------------------------------
  // helpers
  //----------------------------------------
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic log_error(input string msg);
    $display("error at time %0t: %s", $time, msg);
    other_errors++;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expv,
                                 input logic [31:0] actv);
    $display("mismatch at time %0t: %s expected %0h got %0h", $time, name, expv, actv);
    mismatches++;
  endtask

  function automatic int operand_count(input logic [7:0] op);
    case (op)
      "W", "R":           return 2;
      "T", "C", "E", "P": return 1;
      "I":                return 0;
      default:            return -1;
    endcase
  endfunction

  function automatic logic is_space(input logic [7:0] ch);
    return (ch == " ") || (ch == 8'h0a) || (ch == 8'h0d) || (ch == 8'h09);
  endfunction

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    reg_addr  = reg_addr_e'(addr[1:0]);
    reg_wdata = data[REG_DATA_W-1:0];
    reg_wr    = 1'b1;
    next_cycle();
    reg_wr = 1'b0;
    // the sck watch expects half period plus one high cycles
    if (addr[1:0] == REG_CTRL)
      exp_half = 32'(data[CTRL_DIV_LSB +: CTRL_DIV_W]);
  endtask

  task automatic read_reg(input logic [31:0] addr, input logic [31:0] expv);
    reg_addr = reg_addr_e'(addr[1:0]);
    reg_rd   = 1'b1;
    next_cycle();
    reg_rd = 1'b0;
    if (reg_rdata !== expv[REG_DATA_W-1:0])
      report_mismatch("reg_rdata", expv, 32'(reg_rdata));
  endtask

  // push one byte and spend a host credit
  task automatic send_tx(input spi_byte_t value);
    int waited;
    waited = 0;
    while (host_credits == 0 && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (host_credits == 0) begin
      log_error("timeout waiting for a tx credit");
      aborted = 1'b1;
    end else begin
      tx_data  = value;
      tx_valid = 1'b1;
      host_credits--;
      tx_sent++;
      next_cycle();
      tx_valid = 1'b0;
    end
  endtask

  // one rx_credit pulse per granted byte
  task automatic grant_rx(input int count);
    int i;
    for (i = 0; i < count; i++) begin
      rx_credit = 1'b1;
      rx_owed++;
      next_cycle();
    end
    rx_credit = 1'b0;
  endtask

  task automatic expect_rx(input spi_byte_t value);
    int waited;
    spi_byte_t got;
    waited = 0;
    while (rx_seen.size() == 0 && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (rx_seen.size() == 0) begin
      log_error("timeout waiting for an rx byte");
      aborted = 1'b1;
    end else begin
      got = rx_seen.pop_front();
      if (got !== value)
        report_mismatch("rx_data", 32'(value), 32'(got));
    end
  endtask

  // idle means busy clear in two status samples in a row
  // between bytes of a burst busy drops for one cycle only
  task automatic wait_idle();
    int waited;
    int clear_reads;
    logic [REG_DATA_W-1:0] status;
    waited      = 0;
    clear_reads = 0;
    status      = '0;
    reg_addr    = REG_STATUS;
    while (clear_reads < 2 && waited < TIMEOUT) begin
      reg_rd = 1'b1;
      next_cycle();
      status = reg_rdata;
      if (!status[STAT_BUSY])
        clear_reads++;
      else
        clear_reads = 0;
      waited++;
    end
    reg_rd = 1'b0;
    if (clear_reads < 2) begin
      log_error("timeout waiting for the engine to go idle");
      aborted = 1'b1;
    end else if (status[STAT_TX_EMPTY]) begin
      // every byte taken from the queue returned one credit
      if (tx_pulses != tx_sent)
        report_mismatch("tx_credit pulses", 32'(tx_sent), 32'(tx_pulses));
    end
  endtask

  task automatic check_ss_pin(input logic level);
    if (spi_ss_n !== level)
      report_mismatch("spi_ss_n", 32'(level), 32'(spi_ss_n));
  endtask

  //----------------------------------------
  // stream and pin monitor
  //----------------------------------------
  // outputs are settled at mid cycle
  always @(negedge clk) begin
    if (monitor_on) begin
      if (tx_credit) begin
        host_credits++;
        tx_pulses++;
        // each byte taken from the queue owes eight sck rises
        rises_owed += 8;
        if (host_credits > TX_DEPTH)
          log_error("more tx credits returned than bytes sent");
      end
      if (rx_valid) begin
        if (rx_owed == 0)
          log_error("rx_valid raised with no rx credit granted");
        else
          rx_owed--;
        rx_seen.push_back(rx_data);
      end
      // sck high time per pulse
      if (spi_sck) begin
        high_cnt++;
      end else if (high_cnt != 0) begin
        if (high_cnt != exp_half + 1)
          report_mismatch("sck high cycles", 32'(exp_half + 1), 32'(high_cnt));
        high_cnt = 0;
      end
      if (!spi_ss_n && spi_sck && !prev_sck)
        rises_owed--;
      // select may only rise once every started byte has clocked out
      if (spi_ss_n && !prev_ss_n) begin
        if (rises_owed != 0)
          log_error("spi_ss_n rose in the middle of a byte");
        rises_owed = 0;
      end
      prev_sck  = spi_sck;
      prev_ss_n = spi_ss_n;
    end
  end

  //----------------------------------------
  // main sequence
  //----------------------------------------
  initial begin
    int fd;
    int c;
    int n;
    int want;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;

    reset_n      = 1'b0;
    reg_wr       = 1'b0;
    reg_rd       = 1'b0;
    reg_addr     = REG_CTRL;
    reg_wdata    = '0;
    tx_valid     = 1'b0;
    tx_data      = '0;
    rx_credit    = 1'b0;
    mismatches   = 0;
    other_errors = 0;
    host_credits = TX_DEPTH;
    tx_sent      = 0;
    tx_pulses    = 0;
    rx_owed      = 0;
    exp_half     = 0;
    high_cnt     = 0;
    rises_owed   = 0;
    prev_sck     = 1'b0;
    prev_ss_n    = 1'b1;
    monitor_on   = 1'b0;
    aborted      = 1'b0;
    a            = '0;
    b            = '0;

    repeat (16) @(posedge clk);
    #2;
    reset_n = 1'b1;
    next_cycle();

    // pins and streams right after reset
    if (spi_ss_n !== 1'b1)
      report_mismatch("spi_ss_n", 32'(1), 32'(spi_ss_n));
    if (spi_sck !== 1'b0)
      report_mismatch("spi_sck", 32'(0), 32'(spi_sck));
    if (spi_mosi !== 1'b0)
      report_mismatch("spi_mosi", 32'(0), 32'(spi_mosi));
    if (tx_credit !== 1'b0)
      report_mismatch("tx_credit", 32'(0), 32'(tx_credit));
    if (rx_valid !== 1'b0)
      report_mismatch("rx_valid", 32'(0), 32'(rx_valid));
    monitor_on = 1'b1;

    fd = $fopen("verification/spi_patterns.txt", "r");
    if (fd == 0) begin
      log_error("cannot open verification/spi_patterns.txt");
      aborted = 1'b1;
    end

    c = 0;
    while (!aborted && c >= 0) begin
      c  = $fgetc(fd);
      op = c[7:0];
      if (c >= 0 && op == "#") begin
        // comment runs to the end of the line
        while (c >= 0 && c != 10)
          c = $fgetc(fd);
      end else if (c >= 0 && !is_space(op)) begin
        want = operand_count(op);
        n    = 0;
        if (want == 2)
          n = $fscanf(fd, "%h %h", a, b);
        else if (want == 1)
          n = $fscanf(fd, "%h", a);
        if (want < 0 || n != want) begin
          log_error("unknown or malformed pattern line");
          aborted = 1'b1;
        end else begin
          case (op)
            "W": write_reg(a, b);
            "R": read_reg(a, b);
            "T": send_tx(a[7:0]);
            "C": grant_rx(int'(a));
            "E": expect_rx(a[7:0]);
            "I": wait_idle();
            "P": check_ss_pin(a[0]);
            default: log_error("pattern opcode without a handler");
          endcase
        end
      end
    end
    if (fd != 0)
      $fclose(fd);

    if (!aborted && rx_seen.size() != 0)
      log_error("rx bytes arrived that no pattern expected");

    $display("run done: %0d mismatches, %0d other errors", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verification/spi_flash_model.sv */
`timescale 1ns/1ps

module spi_flash_model (
  input  logic spi_ss_n,
  input  logic spi_sck,
  input  logic spi_mosi,
  output logic spi_miso
);

  // answer line, idles high like a pulled up miso
  logic miso_q = 1'b1;
  // mosi bit taken at the last rising sck
  logic mosi_bit = 1'b0;
  // select level seen at the previous event
  logic ss_last = 1'b1;

  assign spi_miso = miso_q;

  //----------------------------------------
  // mode 0 slave
  //----------------------------------------
  // the flash reads mosi on the rising edge
  always @(posedge spi_sck) begin
    mosi_bit <= spi_mosi;
  end

  // a select edge resets the answer to ones
  // a falling sck inside the window shifts out the inverted bit
  always @(posedge spi_ss_n or negedge spi_ss_n or negedge spi_sck) begin
    if (spi_ss_n !== ss_last) begin
      miso_q  <= 1'b1;
      ss_last = spi_ss_n;
    end else if (spi_ss_n === 1'b0) begin
      miso_q <= ~mosi_bit;
    end
  end

endmodule

/* hw/spi_flash_port.sv */
`timescale 1ns/1ps

module spi_flash_port import spi_regmap_pkg::*, spi_link_pkg::*; #(
  parameter int TX_DEPTH = DEF_TX_DEPTH,
  parameter int RX_DEPTH = DEF_RX_DEPTH
) (
  input  logic                  clk,
  input  logic                  reset_n,
  // register port
  input  logic                  reg_wr,
  input  logic                  reg_rd,
  input  reg_addr_e             reg_addr,
  input  logic [REG_DATA_W-1:0] reg_wdata,
  output logic [REG_DATA_W-1:0] reg_rdata,
  // tx byte stream
  input  logic                  tx_valid,
  input  spi_byte_t             tx_data,
  output logic                  tx_credit,
  // rx byte stream
  output logic                  rx_valid,
  output spi_byte_t             rx_data,
  input  logic                  rx_credit,
  // flash pins
  output logic                  spi_ss_n,
  output logic                  spi_sck,
  output logic                  spi_mosi,
  input  logic                  spi_miso
);

  spi_byte_t             tx_head;
  logic                  tx_empty;
  logic                  tx_pop;
  spi_byte_t             rx_byte;
  logic                  rx_push;
  logic                  rx_full;
  logic                  rx_empty;
  spi_byte_t             rx_head;
  logic                  rx_pop;
  logic                  busy;
  logic                  ss_enable;
  logic [CTRL_DIV_W-1:0] half_period;

  // each byte the engine takes frees one host credit
  assign tx_credit = tx_pop;

  //----------------------------------------
  // byte queues
  //----------------------------------------
  // tx full is not wired out, the host credit count covers it
  byte_fifo #(.DEPTH(TX_DEPTH)) tx_q (
    .clk(clk), .reset_n(reset_n), .push(tx_valid), .push_data(tx_data),
    .pop(tx_pop), .head(tx_head), .full(), .empty(tx_empty)
  );

  byte_fifo #(.DEPTH(RX_DEPTH)) rx_q (
    .clk(clk), .reset_n(reset_n), .push(rx_push), .push_data(rx_byte),
    .pop(rx_pop), .head(rx_head), .full(rx_full), .empty(rx_empty)
  );

  //----------------------------------------
  // engine, registers, rx sender
  //----------------------------------------
  spi_byte_engine engine (
    .clk(clk), .reset_n(reset_n), .ss_enable(ss_enable), .half_period(half_period),
    .tx_empty(tx_empty), .tx_byte(tx_head), .tx_pop(tx_pop),
    .rx_full(rx_full), .rx_push(rx_push), .rx_byte(rx_byte), .busy(busy),
    .spi_ss_n(spi_ss_n), .spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
  );

  spi_ctrl_regs regs (
    .clk(clk), .reset_n(reset_n), .reg_wr(reg_wr), .reg_rd(reg_rd),
    .reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
    .busy(busy), .tx_empty(tx_empty), .rx_empty(rx_empty),
    .ss_enable(ss_enable), .half_period(half_period)
  );

  rx_credit_sender rx_send (
    .clk(clk), .reset_n(reset_n), .rx_credit(rx_credit), .rx_empty(rx_empty),
    .rx_head(rx_head), .rx_pop(rx_pop), .rx_valid(rx_valid), .rx_data(rx_data)
  );

endmodule

/* hw/rx_credit_sender.sv */
`timescale 1ns/1ps

module rx_credit_sender import spi_link_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  logic      rx_credit,
  input  logic      rx_empty,
  input  spi_byte_t rx_head,
  output logic      rx_pop,
  output logic      rx_valid,
  output spi_byte_t rx_data
);

  // credits granted by the host and not yet spent
  logic [7:0] credit_cnt;

  // send whenever a credit and a byte are both there
  assign rx_pop = (credit_cnt != 8'd0) && !rx_empty;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      credit_cnt <= '0;
      rx_valid   <= 1'b0;
    end else begin
      // grant and spend in one cycle cancel out
      case ({rx_credit, rx_pop})
        2'b10:   credit_cnt <= credit_cnt + 8'd1;
        2'b01:   credit_cnt <= credit_cnt - 8'd1;
        default: credit_cnt <= credit_cnt;
      endcase
      rx_valid <= rx_pop;
    end
  end

  // output byte register, qualified by rx_valid
  always_ff @(posedge clk) begin
    if (rx_pop)
      rx_data <= rx_head;
  end

endmodule

/* hw/spi_ctrl_regs.sv */
`timescale 1ns/1ps

module spi_ctrl_regs import spi_regmap_pkg::*; (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  reg_wr,
  input  logic                  reg_rd,
  input  reg_addr_e             reg_addr,
  input  logic [REG_DATA_W-1:0] reg_wdata,
  output logic [REG_DATA_W-1:0] reg_rdata,
  input  logic                  busy,
  input  logic                  tx_empty,
  input  logic                  rx_empty,
  output logic                  ss_enable,
  output logic [CTRL_DIV_W-1:0] half_period
);

  logic [REG_DATA_W-1:0] ctrl_word;
  logic [REG_DATA_W-1:0] status_word;

  //----------------------------------------
  // read views
  //----------------------------------------
  // control readback mirrors the stored fields
  always_comb begin
    ctrl_word                             = '0;
    ctrl_word[CTRL_SS_BIT]                = ss_enable;
    ctrl_word[CTRL_DIV_LSB +: CTRL_DIV_W] = half_period;
  end

  // status is live engine and queue state
  always_comb begin
    status_word                = '0;
    status_word[STAT_BUSY]     = busy;
    status_word[STAT_TX_EMPTY] = tx_empty;
    status_word[STAT_RX_EMPTY] = rx_empty;
    status_word[STAT_SS]       = ss_enable;
  end

  //----------------------------------------
  // control register
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ss_enable   <= 1'b0;
      half_period <= '0;
    end else if (reg_wr && (reg_addr == REG_CTRL)) begin
      ss_enable   <= reg_wdata[CTRL_SS_BIT];
      half_period <= reg_wdata[CTRL_DIV_LSB +: CTRL_DIV_W];
    end
  end

  // registered read data, valid the cycle after reg_rd
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      reg_rdata <= '0;
    end else if (reg_rd) begin
      case (reg_addr)
        REG_CTRL:   reg_rdata <= ctrl_word;
        REG_STATUS: reg_rdata <= status_word;
        // unused addresses read as zero
        default:    reg_rdata <= '0;
      endcase
    end
  end

endmodule

/* hw/spi_byte_engine.sv */
`timescale 1ns/1ps

module spi_byte_engine import spi_link_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       ss_enable,
  input  logic [7:0] half_period,
  input  logic       tx_empty,
  input  spi_byte_t  tx_byte,
  output logic       tx_pop,
  input  logic       rx_full,
  output logic       rx_push,
  output spi_byte_t  rx_byte,
  output logic       busy,
  output logic       spi_ss_n,
  output logic       spi_sck,
  output logic       spi_mosi,
  input  logic       spi_miso
);

  engine_state_e state;
  logic [7:0]    phase_cnt;
  logic [2:0]    bit_cnt;
  spi_byte_t     tx_shift;
  spi_byte_t     rx_shift;
  logic          miso_s0;
  logic          miso_s1;
  logic          start;
  logic          sample;
  logic          phase_done;
  logic          no_wait;
  logic          last_bit;

  // a byte starts only with cs on, data queued and room for the answer
  assign start      = (state == IDLE) && ss_enable && !tx_empty && !rx_full;
  // rx is sampled in the cycle that raises sck
  assign sample     = (state == POS_FLANK) || (state == NEXT);
  assign phase_done = (phase_cnt == half_period);
  // half period 0 skips the wait states entirely
  assign no_wait    = (half_period == 8'd0);
  assign last_bit   = (bit_cnt == 3'd7);

  assign tx_pop   = start;
  assign rx_push  = (state == STORE);
  assign rx_byte  = rx_shift;
  assign busy     = (state != IDLE);
  // msb first
  assign spi_mosi = tx_shift[7];

  //----------------------------------------
  // miso capture
  //----------------------------------------
  // two flop synchronizer, then shift at each rising flank
  // the first sample of a byte holds the answer to the previous byte's last bit
  always_ff @(posedge clk) begin
    miso_s0 <= spi_miso;
    miso_s1 <= miso_s0;
    if (sample)
      rx_shift <= {rx_shift[6:0], miso_s1};
  end

  //----------------------------------------
  // byte fsm
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state     <= IDLE;
      spi_ss_n  <= 1'b1;
      spi_sck   <= 1'b0;
      tx_shift  <= '0;
      phase_cnt <= '0;
      bit_cnt   <= '0;
    end else begin
      // chip select only follows the register between bytes
      if ((state == IDLE) || (state == STORE))
        spi_ss_n <= ~ss_enable;

      case (state)
        IDLE: begin
          if (start) begin
            tx_shift  <= tx_byte;
            bit_cnt   <= '0;
            phase_cnt <= '0;
            state     <= LOAD;
          end
        end

        // setup time after cs falls, half_period + 1 cycles
        LOAD: begin
          if (phase_done)
            state <= POS_FLANK;
          else
            phase_cnt <= phase_cnt + 8'd1;
        end

        // rising flank, next bit counted except for the first one
        POS_FLANK, NEXT: begin
          spi_sck   <= 1'b1;
          phase_cnt <= 8'd1;
          if (state == NEXT)
            bit_cnt <= bit_cnt + 3'd1;
          state <= no_wait ? NEG_FLANK : WAIT_POS;
        end

        // high phase is wait cycles plus the neg flank cycle
        WAIT_POS: begin
          if (phase_done)
            state <= NEG_FLANK;
          else
            phase_cnt <= phase_cnt + 8'd1;
        end

        // falling flank, mosi moves with it
        NEG_FLANK: begin
          spi_sck   <= 1'b0;
          phase_cnt <= 8'd1;
          if (last_bit) begin
            state <= STORE;
          end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
            state    <= no_wait ? NEXT : WAIT_NEG;
          end
        end

        // low phase is wait cycles plus the next cycle
        WAIT_NEG: begin
          if (phase_done)
            state <= NEXT;
          else
            phase_cnt <= phase_cnt + 8'd1;
        end

        // rx_push goes out here
        STORE: begin
          state <= IDLE;
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // the register block must not retune sck mid byte
  assert property (@(posedge clk) disable iff (!reset_n)
    (busy && $past(busy)) |-> $stable(half_period))
    else $error("half_period changed while the engine was busy");

  // rx room was checked at start and only the engine fills the rx queue
  assert property (@(posedge clk) disable iff (!reset_n) rx_push |-> !rx_full)
    else $error("rx_push while rx queue full");

endmodule

/* hw/byte_fifo.sv */
`timescale 1ns/1ps

module byte_fifo import spi_link_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic      clk,
  input  logic      reset_n,
  input  logic      push,
  input  spi_byte_t push_data,
  input  logic      pop,
  output spi_byte_t head,
  output logic      full,
  output logic      empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  spi_byte_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // pointer advance with wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign head  = mem[rd_ptr];
  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

  // storage array
  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  //----------------------------------------
  // pointers and occupancy
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (pop)
        rd_ptr <= ptr_inc(rd_ptr);
      // push and pop together keep the count
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // producer must hold off when no room is left
  assert property (@(posedge clk) disable iff (!reset_n) push |-> !full)
    else $error("byte_fifo push while full");
  assert property (@(posedge clk) disable iff (!reset_n) pop |-> !empty)
    else $error("byte_fifo pop while empty");

endmodule

/* hw/spi_link_pkg.sv */
package spi_link_pkg;

  //----------------------------------------
  // byte stream types
  //----------------------------------------

  // one byte on the wire and in the queues
  typedef logic [7:0] spi_byte_t;

  // byte engine states
  // load and store frame the eight bit cycles of one byte
  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    POS_FLANK,
    WAIT_POS,
    NEG_FLANK,
    WAIT_NEG,
    NEXT,
    STORE
  } engine_state_e;

  //----------------------------------------
  // queue defaults
  //----------------------------------------
  // the host starts with DEF_TX_DEPTH tx credits
  localparam int DEF_TX_DEPTH = 4;
  localparam int DEF_RX_DEPTH = 4;

endpackage

/* hw/spi_regmap_pkg.sv */
package spi_regmap_pkg;

  //----------------------------------------
  // register map
  //----------------------------------------

  // host visible register addresses
  typedef enum logic [1:0] {
    REG_CTRL   = 2'd0,
    REG_STATUS = 2'd1
  } reg_addr_e;

  // width of the register data bus
  localparam int REG_DATA_W = 16;

  // control register layout
  localparam int CTRL_SS_BIT  = 0;
  // sck half period field, bits 15..8
  localparam int CTRL_DIV_LSB = 8;
  localparam int CTRL_DIV_W   = 8;

  // status register layout, all read only
  localparam int STAT_BUSY     = 0;
  localparam int STAT_TX_EMPTY = 1;
  localparam int STAT_RX_EMPTY = 2;
  localparam int STAT_SS       = 3;

endpackage
